// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Processor configuration
//////////////////////////////////////////////////////////////////////

// Width of a data word, a ROM address and a bus address
`define CPU_DATA_W 8

// ROM locations holding the thread start addresses
// Mouse vector sits at the top of ROM
`define CPU_MOUSE_VECTOR 8'hFF
// Timer vector sits just below it
`define CPU_TIMER_VECTOR 8'hFE

// Bus address presented whenever no read or write is in progress
// Peripherals decode this as an unused slot
`define CPU_IDLE_BUS_ADDR 8'hFF

`endif

// File: cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	// Data or address word
	typedef logic [`CPU_DATA_W-1:0] word_t;

	// Instruction code, low nibble of the instruction byte
	// Codes 9 to C fall through to no-op
	typedef enum logic [3:0] {
		OP_READ_A  = 4'h0,
		OP_READ_B  = 4'h1,
		OP_WRITE_A = 4'h2,
		OP_WRITE_B = 4'h3,
		OP_MATHS_A = 4'h4,
		OP_MATHS_B = 4'h5,
		OP_BRANCH  = 4'h6,
		OP_GOTO    = 4'h7,
		OP_IDLE    = 4'h8,
		OP_NOP     = 4'hD,
		OP_LOAD_A  = 4'hE,
		OP_LOAD_B  = 4'hF
	} opcode_e;

	// ALU code, high nibble of the instruction byte
	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR  = 4'h3,
		ALU_XOR = 4'h4,
		ALU_SHL = 4'h5,
		ALU_SHR = 4'h6,
		ALU_INC = 4'h7,
		ALU_DEC = 4'h8,
		ALU_EQ  = 4'h9,
		ALU_GT  = 4'hA,
		ALU_LT  = 4'hB
	} aluOp_e;

	// Sequencer states, grouped by instruction in the upper nibble
	typedef enum logic [7:0] {
		ST_IDLE     = 8'hF0,
		ST_THREAD_0 = 8'hF1,
		ST_THREAD_1 = 8'hF2,
		ST_THREAD_2 = 8'hF3,
		ST_DECODE   = 8'h00,
		ST_READ_A   = 8'h10,
		ST_READ_B   = 8'h11,
		ST_READ_0   = 8'h12,
		ST_READ_1   = 8'h13,
		ST_READ_2   = 8'h14,
		ST_LOAD_A   = 8'h15,
		ST_LOAD_A_0 = 8'h16,
		ST_LOAD_B   = 8'h17,
		ST_LOAD_B_0 = 8'h18,
		ST_WRITE_A  = 8'h20,
		ST_WRITE_B  = 8'h21,
		ST_WRITE_0  = 8'h22,
		ST_MATHS_A  = 8'h30,
		ST_MATHS_B  = 8'h31,
		ST_MATHS_0  = 8'h32,
		ST_BRANCH   = 8'h40,
		ST_BRANCH_0 = 8'h41,
		ST_BRANCH_1 = 8'h42,
		ST_GOTO     = 8'h50,
		ST_GOTO_0   = 8'h51,
		ST_GOTO_1   = 8'h52,
		ST_NOP      = 8'h84
	} cpuState_e;

	// Program counter action for the next cycle
	typedef enum logic [2:0] {
		PC_HOLD,
		PC_INC1,
		PC_INC2,
		PC_LOAD_ROM,
		PC_MOUSE_VEC,
		PC_TIMER_VEC
	} pcOp_e;

	// Fetch control, offset flag points the ROM at the operand byte
	typedef struct packed {
		pcOp_e pcOp;
		logic  offset;
	} fetchCtl_t;

	// Register file write target and data source
	typedef enum logic [1:0] {DST_NONE, DST_A, DST_B} regDst_e;
	typedef enum logic [1:0] {SRC_BUS, SRC_ROM, SRC_ALU} regSrc_e;

	// Bus address source, the last one also raises the write enable
	typedef enum logic [1:0] {ADDR_IDLE, ADDR_ROM, ADDR_ROM_WRITE} busAddrSrc_e;

	// Execute control
	typedef struct packed {
		regDst_e     regDst;
		regSrc_e     regSrc;
		busAddrSrc_e busAddrSrc;
		logic        wrSelB;
	} execCtl_t;

endpackage

// File: cpuFetch.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuFetch (
	input  logic               CLK,
	input  logic               RESET,
	input  cpu_pkg::fetchCtl_t fetchCtl,
	input  cpu_pkg::word_t     romData,
	output cpu_pkg::word_t     romAddr
);
	import cpu_pkg::*;

	// Program counter and its next value
	word_t pc;
	word_t pcNext;
	// Operand offset, high for one cycle after decode
	logic offset;

	//////////////////////////////////////////////////////////////////////
	// Next program counter
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		pcNext = pc;
		case (fetchCtl.pcOp)
			PC_HOLD:      pcNext = pc;
			// One-byte instructions
			PC_INC1:      pcNext = pc + word_t'(1);
			// Two-byte instructions, skip the operand
			PC_INC2:      pcNext = pc + word_t'(2);
			// Jump target or thread start from the ROM
			PC_LOAD_ROM:  pcNext = romData;
			// Point at the vector slot of the interrupt
			PC_MOUSE_VEC: pcNext = `CPU_MOUSE_VECTOR;
			PC_TIMER_VEC: pcNext = `CPU_TIMER_VECTOR;
			default:      pcNext = pc;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (RESET) begin
			// Execution starts at ROM address 0
			pc     <= '0;
			offset <= 1'b0;
		end else begin
			pc     <= pcNext;
			offset <= fetchCtl.offset;
		end
	end

	// ROM address, the ROM answers one cycle later
	assign romAddr = pc + word_t'(offset);

endmodule

// File: cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer (
	input  logic               CLK,
	input  logic               RESET,
	input  cpu_pkg::word_t     romData,
	input  logic               branchTaken,
	input  logic               mouseIrq,
	input  logic               timerIrq,
	output logic               mouseAck,
	output logic               timerAck,
	output cpu_pkg::fetchCtl_t fetchCtl,
	output cpu_pkg::execCtl_t  execCtl
);
	import cpu_pkg::*;

	cpuState_e state;
	cpuState_e stateNext;
	// Register chosen by a read or write, high selects B
	logic regSel;
	logic regSelNext;
	logic mouseAckNext;
	logic timerAckNext;
	// Opcode of the byte on the ROM data lines
	opcode_e opcode;

	assign opcode = opcode_e'(romData[3:0]);

	//////////////////////////////////////////////////////////////////////
	// State and acknowledge registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (RESET) begin
			// Settle state, so the first decode sees ROM address 0
			state    <= ST_THREAD_2;
			regSel   <= 1'b0;
			mouseAck <= 1'b0;
			timerAck <= 1'b0;
		end else begin
			state    <= stateNext;
			regSel   <= regSelNext;
			mouseAck <= mouseAckNext;
			timerAck <= timerAckNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state and stage controls
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		stateNext    = state;
		regSelNext   = regSel;
		mouseAckNext = 1'b0;
		timerAckNext = 1'b0;
		// Quiet defaults, nothing moves and the bus is idle
		fetchCtl = '{pcOp: PC_HOLD, offset: 1'b0};
		execCtl  = '{regDst: DST_NONE, regSrc: SRC_ALU, busAddrSrc: ADDR_IDLE, wrSelB: regSel};
		case (state)
			// Sleep until an interrupt, mouse wins a tie
			ST_IDLE: begin
				if (mouseIrq) begin
					stateNext     = ST_THREAD_0;
					fetchCtl.pcOp = PC_MOUSE_VEC;
					mouseAckNext  = 1'b1;
				end else if (timerIrq) begin
					stateNext     = ST_THREAD_0;
					fetchCtl.pcOp = PC_TIMER_VEC;
					timerAckNext  = 1'b1;
				end
			end
			// Wait for the vector byte
			ST_THREAD_0: stateNext = ST_THREAD_1;
			// Thread start address into the program counter
			ST_THREAD_1: begin
				stateNext     = ST_THREAD_2;
				fetchCtl.pcOp = PC_LOAD_ROM;
			end
			// Wait for the first instruction byte
			ST_THREAD_2: stateNext = ST_DECODE;
			// Pick the instruction, ROM moves to the operand byte
			ST_DECODE: begin
				fetchCtl.offset = 1'b1;
				case (opcode)
					OP_READ_A:  stateNext = ST_READ_A;
					OP_READ_B:  stateNext = ST_READ_B;
					OP_WRITE_A: stateNext = ST_WRITE_A;
					OP_WRITE_B: stateNext = ST_WRITE_B;
					OP_MATHS_A: stateNext = ST_MATHS_A;
					OP_MATHS_B: stateNext = ST_MATHS_B;
					OP_BRANCH:  stateNext = ST_BRANCH;
					OP_GOTO:    stateNext = ST_GOTO;
					OP_IDLE:    stateNext = ST_IDLE;
					OP_LOAD_A:  stateNext = ST_LOAD_A;
					OP_LOAD_B:  stateNext = ST_LOAD_B;
					OP_NOP:     stateNext = ST_NOP;
					default:    stateNext = ST_NOP;
				endcase
			end
			//////////////////////////////////////////////////////////////////////
			// Memory read, address byte then data one cycle after it
			ST_READ_A: begin
				stateNext  = ST_READ_0;
				regSelNext = 1'b0;
			end
			ST_READ_B: begin
				stateNext  = ST_READ_0;
				regSelNext = 1'b1;
			end
			ST_READ_0: begin
				stateNext          = ST_READ_1;
				execCtl.busAddrSrc = ADDR_ROM;
			end
			ST_READ_1: begin
				stateNext     = ST_READ_2;
				fetchCtl.pcOp = PC_INC2;
			end
			ST_READ_2: begin
				stateNext      = ST_DECODE;
				execCtl.regDst = regSel ? DST_B : DST_A;
				execCtl.regSrc = SRC_BUS;
			end
			// Load immediate, operand byte straight into the register
			ST_LOAD_A: begin
				stateNext     = ST_LOAD_A_0;
				fetchCtl.pcOp = PC_INC2;
			end
			ST_LOAD_A_0: begin
				stateNext      = ST_DECODE;
				execCtl.regDst = DST_A;
				execCtl.regSrc = SRC_ROM;
			end
			ST_LOAD_B: begin
				stateNext     = ST_LOAD_B_0;
				fetchCtl.pcOp = PC_INC2;
			end
			ST_LOAD_B_0: begin
				stateNext      = ST_DECODE;
				execCtl.regDst = DST_B;
				execCtl.regSrc = SRC_ROM;
			end
			// Memory write, strobe lands in the next decode
			ST_WRITE_A: begin
				stateNext     = ST_WRITE_0;
				regSelNext    = 1'b0;
				fetchCtl.pcOp = PC_INC2;
			end
			ST_WRITE_B: begin
				stateNext     = ST_WRITE_0;
				regSelNext    = 1'b1;
				fetchCtl.pcOp = PC_INC2;
			end
			ST_WRITE_0: begin
				stateNext          = ST_DECODE;
				execCtl.busAddrSrc = ADDR_ROM_WRITE;
			end
			//////////////////////////////////////////////////////////////////////
			// ALU result is ready while the opcode byte is still on the ROM
			ST_MATHS_A: begin
				stateNext      = ST_MATHS_0;
				fetchCtl.pcOp  = PC_INC1;
				execCtl.regDst = DST_A;
			end
			ST_MATHS_B: begin
				stateNext      = ST_MATHS_0;
				fetchCtl.pcOp  = PC_INC1;
				execCtl.regDst = DST_B;
			end
			ST_MATHS_0: stateNext = ST_DECODE;
			// Branch on a nonzero compare result
			ST_BRANCH: begin
				if (branchTaken) begin
					stateNext = ST_BRANCH_0;
				end else begin
					stateNext     = ST_BRANCH_1;
					fetchCtl.pcOp = PC_INC2;
				end
			end
			ST_BRANCH_0: begin
				stateNext     = ST_BRANCH_1;
				fetchCtl.pcOp = PC_LOAD_ROM;
			end
			ST_BRANCH_1: stateNext = ST_DECODE;
			// Unconditional jump, target is the operand byte
			ST_GOTO:     stateNext = ST_GOTO_0;
			ST_GOTO_0: begin
				stateNext     = ST_GOTO_1;
				fetchCtl.pcOp = PC_LOAD_ROM;
			end
			ST_GOTO_1:   stateNext = ST_DECODE;
			ST_NOP: begin
				stateNext     = ST_DECODE;
				fetchCtl.pcOp = PC_INC1;
			end
			default:     stateNext = ST_IDLE;
		endcase
	end

endmodule

// File: cpuExecute.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuExecute (
	input  logic              CLK,
	input  logic              RESET,
	input  cpu_pkg::execCtl_t execCtl,
	input  cpu_pkg::word_t    romData,
	input  cpu_pkg::word_t    busDataIn,
	output cpu_pkg::word_t    busDataOut,
	output cpu_pkg::word_t    busAddr,
	output logic              busWe,
	output logic              branchTaken
);
	import cpu_pkg::*;

	// Working registers
	word_t regA;
	word_t regB;
	word_t aluOut;
	// Value headed for the selected register
	word_t regIn;
	aluOp_e aluOp;

	// ALU code rides in the high nibble of the instruction
	assign aluOp = aluOp_e'(romData[7:4]);

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (aluOp)
			ALU_ADD: aluOut = regA + regB;
			ALU_SUB: aluOut = regA - regB;
			ALU_AND: aluOut = regA & regB;
			ALU_OR:  aluOut = regA | regB;
			ALU_XOR: aluOut = regA ^ regB;
			ALU_SHL: aluOut = regA << 1;
			ALU_SHR: aluOut = regA >> 1;
			ALU_INC: aluOut = regA + word_t'(1);
			ALU_DEC: aluOut = regA - word_t'(1);
			// Compares give 1 or 0
			ALU_EQ:  aluOut = word_t'(regA == regB);
			ALU_GT:  aluOut = word_t'(regA > regB);
			ALU_LT:  aluOut = word_t'(regA < regB);
			default: aluOut = regA;
		endcase
	end

	// Any nonzero result takes the branch
	assign branchTaken = |aluOut;

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (execCtl.regSrc)
			SRC_BUS: regIn = busDataIn;
			SRC_ROM: regIn = romData;
			SRC_ALU: regIn = aluOut;
			default: regIn = aluOut;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			regA <= '0;
			regB <= '0;
		end else begin
			if (execCtl.regDst == DST_A)
				regA <= regIn;
			if (execCtl.regDst == DST_B)
				regB <= regIn;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data bus, address and strobe registered from the operand byte
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (RESET) begin
			busAddr <= `CPU_IDLE_BUS_ADDR;
			busWe   <= 1'b0;
		end else begin
			busWe <= (execCtl.busAddrSrc == ADDR_ROM_WRITE);
			case (execCtl.busAddrSrc)
				ADDR_ROM, ADDR_ROM_WRITE: busAddr <= romData;
				default:                  busAddr <= `CPU_IDLE_BUS_ADDR;
			endcase
		end
	end

	// Write data, held between writes
	always_ff @(posedge CLK) begin
		if (execCtl.busAddrSrc == ADDR_ROM_WRITE)
			busDataOut <= execCtl.wrSelB ? regB : regA;
	end

endmodule

// File: cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input  logic           CLK,
	input  logic           RESET,
	output cpu_pkg::word_t romAddr,
	input  cpu_pkg::word_t romData,
	output cpu_pkg::word_t busAddr,
	input  cpu_pkg::word_t busDataIn,
	output cpu_pkg::word_t busDataOut,
	output logic           busWe,
	input  logic           mouseIrq,
	input  logic           timerIrq,
	output logic           mouseAck,
	output logic           timerAck
);
	import cpu_pkg::*;

	// Stage controls from the sequencer
	fetchCtl_t fetchCtl;
	execCtl_t  execCtl;
	// Compare result back to the sequencer
	logic branchTaken;

	// Program counter and ROM addressing
	cpuFetch uFetch (
		.CLK      (CLK),
		.RESET    (RESET),
		.fetchCtl (fetchCtl),
		.romData  (romData),
		.romAddr  (romAddr)
	);

	// Instruction FSM and interrupt arbitration
	cpuSequencer uSequencer (
		.CLK         (CLK),
		.RESET       (RESET),
		.romData     (romData),
		.branchTaken (branchTaken),
		.mouseIrq    (mouseIrq),
		.timerIrq    (timerIrq),
		.mouseAck    (mouseAck),
		.timerAck    (timerAck),
		.fetchCtl    (fetchCtl),
		.execCtl     (execCtl)
	);

	// Registers, ALU and data bus
	cpuExecute uExecute (
		.CLK         (CLK),
		.RESET       (RESET),
		.execCtl     (execCtl),
		.romData     (romData),
		.busDataIn   (busDataIn),
		.busDataOut  (busDataOut),
		.busAddr     (busAddr),
		.busWe       (busWe),
		.branchTaken (branchTaken)
	);

endmodule

// File: cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
	input logic CLK,
	input logic RESET,
	input logic busWe,
	input logic mouseAck,
	input logic timerAck
);

	//////////////////////////////////////////////////////////////////////
	// Bus and interrupt protocol
	//////////////////////////////////////////////////////////////////////

	// Write strobe lasts one cycle
	busWePulse: assert property (@(posedge CLK) disable iff (RESET) busWe |=> !busWe)
		else $error("busWe high in two cycles in a row");

	// Only one thread starts at a time
	ackExclusive: assert property (@(posedge CLK) disable iff (RESET) !(mouseAck && timerAck))
		else $error("mouseAck and timerAck high together");

	// Acknowledges are single-cycle pulses
	mouseAckPulse: assert property (@(posedge CLK) disable iff (RESET) mouseAck |=> !mouseAck)
		else $error("mouseAck longer than one cycle");
	timerAckPulse: assert property (@(posedge CLK) disable iff (RESET) timerAck |=> !timerAck)
		else $error("timerAck longer than one cycle");

	// Synchronous reset clears the strobes on the next edge
	resetQuiet: assert property (@(posedge CLK) RESET |=> (!busWe && !mouseAck && !timerAck))
		else $error("busWe or an acknowledge high during reset");

endmodule

bind cpuCore cpu_sva uSva (
	.CLK      (CLK),
	.RESET    (RESET),
	.busWe    (busWe),
	.mouseAck (mouseAck),
	.timerAck (timerAck)
);

// File: tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu;
	import cpu_pkg::*;

	// DUT pins
	logic  CLK;
	logic  RESET;
	logic  mouseIrq;
	logic  timerIrq;
	logic  mouseAck;
	logic  timerAck;
	logic  busWe;
	word_t romAddr;
	word_t romData = '0;
	word_t busAddr;
	word_t busDataIn = '0;
	word_t busDataOut;

	// Program ROM, live data memory and the image it reloads from in reset
	word_t rom [256];
	word_t dataMem [256];
	word_t memImage [256];
	// Bus write log, in order of the strobes
	word_t writeAddr [$];
	word_t writeData [$];
	int    mouseAckCount = 0;
	int    timerAckCount = 0;
	// Next free ROM location for the program builder
	word_t romPtr;
	logic [31:0] rngState = 32'h2db8_ad61;

	cpuCore DUT (
		.CLK        (CLK),
		.RESET      (RESET),
		.romAddr    (romAddr),
		.romData    (romData),
		.busAddr    (busAddr),
		.busDataIn  (busDataIn),
		.busDataOut (busDataOut),
		.busWe      (busWe),
		.mouseIrq   (mouseIrq),
		.timerIrq   (timerIrq),
		.mouseAck   (mouseAck),
		.timerAck   (timerAck)
	);

	// 10 ns clock
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory models and monitors
	//////////////////////////////////////////////////////////////////////
	always @(posedge CLK) begin
		// Both memories answer one cycle after the address
		romData   <= rom[romAddr];
		busDataIn <= dataMem[busAddr];
		if (RESET) begin
			dataMem <= memImage;
			writeAddr.delete();
			writeData.delete();
			mouseAckCount <= 0;
			timerAckCount <= 0;
		end else begin
			if (busWe) begin
				dataMem[busAddr] <= busDataOut;
				writeAddr.push_back(busAddr);
				writeData.push_back(busDataOut);
			end
			if (mouseAck)
				mouseAckCount <= mouseAckCount + 1;
			if (timerAck)
				timerAckCount <= timerAckCount + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic randomByte(output word_t value);
		rngState = xorshift(rngState);
		value = rngState[7:0];
	endtask

	// Reference ALU, straight from the instruction set table
	function automatic word_t aluExpected(input logic [3:0] op, input word_t a, input word_t b);
		case (op)
			4'h0: return a + b;
			4'h1: return a - b;
			4'h2: return a & b;
			4'h3: return a | b;
			4'h4: return a ^ b;
			4'h5: return {a[6:0], 1'b0};
			4'h6: return {1'b0, a[7:1]};
			4'h7: return a + 8'd1;
			4'h8: return a - 8'd1;
			4'h9: return (a == b) ? 8'd1 : 8'd0;
			4'hA: return (a > b) ? 8'd1 : 8'd0;
			4'hB: return (a < b) ? 8'd1 : 8'd0;
			default: return a;
		endcase
	endfunction

	task automatic checkEqual(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic expectWrite(input int idx, input word_t addr, input word_t data);
		checkEqual(int'(writeAddr[idx]), int'(addr), $sformatf("address of bus write %0d", idx));
		checkEqual(int'(writeData[idx]), int'(data), $sformatf("data of bus write %0d", idx));
	endtask

	// Program builder, one task per instruction form
	task automatic putByte(input word_t value);
		rom[romPtr] = value;
		romPtr = romPtr + 8'd1;
	endtask

	task automatic loadImm(input logic isB, input word_t value);
		putByte(isB ? 8'h0F : 8'h0E);
		putByte(value);
	endtask

	task automatic storeReg(input logic isB, input word_t addr);
		putByte(isB ? 8'h03 : 8'h02);
		putByte(addr);
	endtask

	task automatic readMem(input logic isB, input word_t addr);
		putByte(isB ? 8'h01 : 8'h00);
		putByte(addr);
	endtask

	task automatic aluInto(input logic [3:0] code, input logic isB);
		putByte({code, isB ? 4'h5 : 4'h4});
	endtask

	task automatic branchIf(input logic [3:0] code, input word_t target);
		putByte({code, 4'h6});
		putByte(target);
	endtask

	task automatic jumpTo(input word_t target);
		putByte(8'h07);
		putByte(target);
	endtask

	task automatic sleepCpu();
		putByte(8'h08);
	endtask

	// Reset on, ROM filled with no-ops, memory image with an address pattern
	task automatic holdInReset();
		@(posedge CLK);
		#1;
		RESET = 1'b1;
		mouseIrq = 1'b0;
		timerIrq = 1'b0;
		for (int i = 0; i < 256; i++) begin
			rom[i[7:0]] = {i[7:4] ^ i[3:0], 4'hD};
			memImage[i[7:0]] = {i[3:0], i[7:4]} ^ 8'h3C;
		end
		romPtr = 8'h00;
	endtask

	task automatic releaseReset();
		repeat (3) @(posedge CLK);
		#1;
		RESET = 1'b0;
	endtask

	task automatic collectWrites(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (writeAddr.size() < count && cycles < limit) begin
			@(negedge CLK);
			cycles++;
		end
		if (writeAddr.size() < count) begin
			$display("Timed out after %0d cycles waiting for %0d bus writes", limit, count);
			$display("Errors found");
			$fatal(1);
		end
		// Stray writes from skipped code would land here
		repeat (16) @(negedge CLK);
		checkEqual(writeAddr.size(), count, "number of bus writes");
	endtask

	task automatic awaitAck(input logic wantMouse, input int limit);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit) begin
			@(negedge CLK);
			seen = wantMouse ? mouseAck : timerAck;
			cycles++;
		end
		if (!seen) begin
			$display("Timed out waiting for the %s acknowledge", wantMouse ? "mouse" : "timer");
			$display("Errors found");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic immediateStores();
		word_t a;
		word_t b;
		$display("Load-immediate and write");
		randomByte(a);
		randomByte(b);
		holdInReset();
		loadImm(1'b0, a);
		loadImm(1'b1, b);
		storeReg(1'b0, 8'h10);
		storeReg(1'b1, 8'h11);
		sleepCpu();
		releaseReset();
		collectWrites(2, 200);
		expectWrite(0, 8'h10, a);
		expectWrite(1, 8'h11, b);
		checkEqual(mouseAckCount, 0, "mouse acknowledges");
		checkEqual(timerAckCount, 0, "timer acknowledges");
	endtask

	task automatic memoryCopy();
		word_t a;
		word_t b;
		$display("Memory read and write back");
		randomByte(a);
		randomByte(b);
		holdInReset();
		memImage[8'h30] = a;
		memImage[8'h31] = b;
		readMem(1'b0, 8'h30);
		readMem(1'b1, 8'h31);
		storeReg(1'b0, 8'h40);
		storeReg(1'b1, 8'h41);
		sleepCpu();
		releaseReset();
		collectWrites(2, 200);
		expectWrite(0, 8'h40, a);
		expectWrite(1, 8'h41, b);
	endtask

	task automatic aluResults();
		word_t opA [16];
		word_t opB [16];
		word_t r;
		$display("ALU codes into A and B");
		holdInReset();
		// Twelve bytes per code, both destinations from the same operands
		for (int code = 0; code < 16; code++) begin
			randomByte(opA[code]);
			randomByte(opB[code]);
			loadImm(1'b0, opA[code]);
			loadImm(1'b1, opB[code]);
			aluInto(code[3:0], 1'b0);
			storeReg(1'b0, word_t'(128 + 2 * code));
			loadImm(1'b0, opA[code]);
			aluInto(code[3:0], 1'b1);
			storeReg(1'b1, word_t'(129 + 2 * code));
		end
		sleepCpu();
		releaseReset();
		collectWrites(32, 1000);
		for (int code = 0; code < 16; code++) begin
			r = aluExpected(code[3:0], opA[code], opB[code]);
			expectWrite(2 * code, word_t'(128 + 2 * code), r);
			expectWrite(2 * code + 1, word_t'(129 + 2 * code), r);
		end
	endtask

	task automatic branchPaths();
		word_t x;
		$display("Branch and goto");
		randomByte(x);
		holdInReset();
		// 00 equal operands, branch taken over the bad store
		loadImm(1'b0, x);
		loadImm(1'b1, x);
		branchIf(4'h9, 8'h0A);
		loadImm(1'b0, 8'hEE);
		storeReg(1'b0, 8'h60);
		// 0A
		loadImm(1'b0, 8'hA1);
		storeReg(1'b0, 8'h50);
		// 0E operands differ in bit 0, falls through
		loadImm(1'b0, x);
		loadImm(1'b1, x ^ 8'h01);
		branchIf(4'h9, 8'h40);
		loadImm(1'b0, 8'hA2);
		storeReg(1'b0, 8'h51);
		// 18 goto skips to 1E
		jumpTo(8'h1E);
		loadImm(1'b0, 8'hEE);
		storeReg(1'b0, 8'h61);
		// 1E
		loadImm(1'b0, 8'hA3);
		storeReg(1'b0, 8'h52);
		sleepCpu();
		// Target of the false branch, must stay silent
		romPtr = 8'h40;
		loadImm(1'b0, 8'hEE);
		storeReg(1'b0, 8'h62);
		sleepCpu();
		releaseReset();
		collectWrites(3, 300);
		expectWrite(0, 8'h50, 8'hA1);
		expectWrite(1, 8'h51, 8'hA2);
		expectWrite(2, 8'h52, 8'hA3);
	endtask

	task automatic interruptThreads();
		word_t tm;
		word_t mm;
		$display("Interrupt threads");
		randomByte(tm);
		randomByte(mm);
		holdInReset();
		sleepCpu();
		rom[`CPU_TIMER_VECTOR] = 8'h20;
		rom[`CPU_MOUSE_VECTOR] = 8'h40;
		// Timer thread
		romPtr = 8'h20;
		loadImm(1'b0, tm);
		storeReg(1'b0, 8'h70);
		sleepCpu();
		// Mouse thread
		romPtr = 8'h40;
		loadImm(1'b0, mm);
		storeReg(1'b0, 8'h71);
		sleepCpu();
		releaseReset();
		@(posedge CLK);
		#1;
		timerIrq = 1'b1;
		awaitAck(1'b0, 10);
		@(posedge CLK);
		#1;
		timerIrq = 1'b0;
		collectWrites(1, 100);
		expectWrite(0, 8'h70, tm);
		checkEqual(mouseAckCount, 0, "mouse acknowledges after timer");
		checkEqual(timerAckCount, 1, "timer acknowledges after timer");
		// Both at once, mouse goes first
		@(posedge CLK);
		#1;
		mouseIrq = 1'b1;
		timerIrq = 1'b1;
		awaitAck(1'b1, 10);
		@(posedge CLK);
		#1;
		mouseIrq = 1'b0;
		timerIrq = 1'b0;
		collectWrites(2, 100);
		expectWrite(1, 8'h71, mm);
		checkEqual(mouseAckCount, 1, "mouse acknowledges after tie");
		checkEqual(timerAckCount, 1, "timer acknowledges after tie");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		RESET = 1'b1;
		mouseIrq = 1'b0;
		timerIrq = 1'b0;
		immediateStores();
		memoryCopy();
		aluResults();
		branchPaths();
		interruptThreads();
		$display("No errors");
		$finish;
	end

endmodule

// File: tb.f
+incdir+.
cpu_pkg.sv
cpuFetch.sv
cpuSequencer.sv
cpuExecute.sv
cpuCore.sv
cpu_sva.sv
tb_cpu.sv

// File: Makefile
all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu -f tb.f

run: build
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module tb_cpu -f tb.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
